//--- common/uart_mmio_consts.svh
`ifndef UART_MMIO_CONSTS_SVH
`define UART_MMIO_CONSTS_SVH

// Serial bit time in clock cycles
`define UART_CLKS_PER_BIT 16

// 32-entry byte FIFOs
`define FIFO_LOGDEPTH 5

// Processor-side address map
`define MMIO_ADDR_STATUS  32'h8000_0000  // Bit 0 tx_ready, bit 1 rx_valid
`define MMIO_ADDR_RX_DATA 32'h8000_0004  // Read pops the RX FIFO
`define MMIO_ADDR_TX_DATA 32'h8000_0008  // Write pushes the TX FIFO
`define MMIO_ADDR_CYCLES  32'h8000_0010
`define MMIO_ADDR_CNT_RST 32'h8000_0018  // Write clears the cycle counter

`endif

//--- common/uart_mmio_pkg.sv
`default_nettype none

package uart_mmio_pkg;

  // One serial payload
  typedef logic [7:0] byte_t;

  // Processor request, taken on the edge where we or re is set
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
    logic        re;
  } mmio_req_t;

  // Read response, one cycle after the request
  typedef struct packed {
    logic [31:0] rdata;
    logic        rvalid;
  } mmio_rsp_t;

endpackage

`default_nettype wire

//--- uart/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mmio_consts.svh"

module uart_tx import uart_mmio_pkg::*; #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic  clk,
  input  logic  arst_n,
  input  byte_t data,
  input  logic  valid,
  output logic  ready,
  output logic  serial_out
);
  localparam int CW = $clog2(CLKS_PER_BIT);

  logic [9:0]    shift_q;   // Whole frame, bit 0 is on the line
  logic [CW-1:0] baud_cnt;
  logic [3:0]    bit_cnt;   // Bits already sent in this frame
  logic          busy;
  logic          bit_end;

  assign bit_end    = busy && (baud_cnt == CW'(CLKS_PER_BIT - 1));
  assign ready      = !busy;
  assign serial_out = shift_q[0];

  // Shifting in ones leaves the line idle high after the stop bit
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shift_q  <= '1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      busy     <= 1'b0;
    end else if (valid && ready) begin
      shift_q  <= {1'b1, data, 1'b0};  // Stop, data LSB first, start
      baud_cnt <= '0;
      bit_cnt  <= '0;
      busy     <= 1'b1;
    end else if (busy) begin
      if (bit_end) begin
        baud_cnt <= '0;
        shift_q  <= {1'b1, shift_q[9:1]};
        bit_cnt  <= bit_cnt + 4'd1;
        if (bit_cnt == 4'd9) begin
          busy <= 1'b0;  // Stop bit done
        end
      end else begin
        baud_cnt <= baud_cnt + CW'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- uart/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mmio_consts.svh"

module uart_rx import uart_mmio_pkg::*; #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  serial_in,
  output byte_t data,
  output logic  valid,
  input  logic  ready
);
  localparam int CW = $clog2(CLKS_PER_BIT);
  // Half a bit plus the two synchronizer stages, so the first sample
  // lands half a bit after the first edge that saw the start
  localparam int START_LOAD = CLKS_PER_BIT / 2 + 2;

  logic          sync_a;
  logic          sync_b;
  logic          active;
  logic [CW-1:0] baud_cnt;
  logic [3:0]    bit_idx;   // 0 start, 1..8 data, 9 stop
  byte_t         shift_q;
  logic          sample;

  assign sample = active && (baud_cnt == CW'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_a <= 1'b1;
      sync_b <= 1'b1;
    end else begin
      sync_a <= serial_in;
      sync_b <= sync_a;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      valid    <= 1'b0;
    end else begin
      if (valid && ready) begin
        valid <= 1'b0;
      end
      if (!active) begin
        if (!sync_b) begin  // Start edge
          active   <= 1'b1;
          baud_cnt <= CW'(START_LOAD);
          bit_idx  <= '0;
        end
      end else if (sample) begin
        baud_cnt <= '0;
        bit_idx  <= bit_idx + 4'd1;
        if (bit_idx == 4'd0 && sync_b) begin
          active <= 1'b0;  // Glitch, not a start bit
        end
        if (bit_idx == 4'd9) begin
          active <= 1'b0;
          // A bad stop bit drops the byte
          if (sync_b) begin
            valid <= 1'b1;
          end
        end
      end else begin
        baud_cnt <= baud_cnt + CW'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample) begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
        shift_q <= {sync_b, shift_q[7:1]};  // LSB arrives first
      end
      if (bit_idx == 4'd9) begin
        data <= shift_q;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mmio_consts.svh"

module byte_fifo import uart_mmio_pkg::*; #(
  parameter int LOGDEPTH = `FIFO_LOGDEPTH
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  enq_valid,
  output logic  enq_ready,
  input  byte_t enq_data,
  output logic  deq_valid,
  input  logic  deq_ready,
  output byte_t deq_data
);
  localparam int DEPTH = 1 << LOGDEPTH;

  byte_t               mem [DEPTH];
  logic [LOGDEPTH-1:0] wr_ptr;  // Wraps on its own
  logic [LOGDEPTH-1:0] rd_ptr;
  logic [LOGDEPTH:0]   count;
  logic                do_enq;
  logic                do_deq;

  assign enq_ready = (count != (LOGDEPTH + 1)'(DEPTH));
  assign deq_valid = (count != '0);
  assign deq_data  = mem[rd_ptr];
  assign do_enq    = enq_valid && enq_ready;
  assign do_deq    = deq_valid && deq_ready;

  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem[wr_ptr] <= enq_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= wr_ptr + LOGDEPTH'(1);
      end
      if (do_deq) begin
        rd_ptr <= rd_ptr + LOGDEPTH'(1);
      end
      // Simultaneous push and pop keeps the count
      if (do_enq && !do_deq) begin
        count <= count + (LOGDEPTH + 1)'(1);
      end else if (do_deq && !do_enq) begin
        count <= count - (LOGDEPTH + 1)'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- design/mmio_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mmio_consts.svh"

module mmio_regs import uart_mmio_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  mmio_req_t req,
  output mmio_rsp_t rsp,
  output logic      tx_enq_valid,
  input  logic      tx_enq_ready,
  output byte_t     tx_enq_data,
  input  logic      rx_deq_valid,
  output logic      rx_deq_ready,
  input  byte_t     rx_deq_data
);
  logic [31:0] cycle_cnt;
  logic [31:0] rdata_d;
  logic [31:0] rdata_q;
  logic        rvalid_q;
  logic        cnt_clr;

  // A full TX FIFO drops the write through enq_ready
  assign tx_enq_valid = req.we && (req.addr == `MMIO_ADDR_TX_DATA);
  assign tx_enq_data  = req.wdata[7:0];
  assign rx_deq_ready = req.re && (req.addr == `MMIO_ADDR_RX_DATA);  // Pop on read
  assign cnt_clr      = req.we && (req.addr == `MMIO_ADDR_CNT_RST);

  // Values seen before the edge that takes the request
  always_comb begin
    case (req.addr)
      `MMIO_ADDR_STATUS:  rdata_d = {30'b0, rx_deq_valid, tx_enq_ready};
      `MMIO_ADDR_RX_DATA: rdata_d = {24'b0, rx_deq_data};
      `MMIO_ADDR_CYCLES:  rdata_d = cycle_cnt;
      default:            rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req.re;
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk) begin
    if (req.re) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cycle_cnt <= '0;
    end else if (cnt_clr) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 32'd1;  // Free running, wraps
    end
  end

  assign rsp = '{rdata: rdata_q, rvalid: rvalid_q};

endmodule

`default_nettype wire

//--- design/uart_mmio_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mmio_consts.svh"

module uart_mmio_top import uart_mmio_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  mmio_req_t req,
  output mmio_rsp_t rsp,
  input  logic      serial_rx,
  output logic      serial_tx
);
  // Register block to TX FIFO
  logic  tx_enq_valid;
  logic  tx_enq_ready;
  byte_t tx_enq_data;
  // TX FIFO to serializer
  logic  tx_deq_valid;
  logic  tx_deq_ready;
  byte_t tx_deq_data;
  // Deserializer to RX FIFO
  logic  rx_enq_valid;
  logic  rx_enq_ready;
  byte_t rx_enq_data;
  // RX FIFO to register block
  logic  rx_deq_valid;
  logic  rx_deq_ready;
  byte_t rx_deq_data;

  mmio_regs regs (
    .clk          (clk),
    .arst_n       (arst_n),
    .req          (req),
    .rsp          (rsp),
    .tx_enq_valid (tx_enq_valid),
    .tx_enq_ready (tx_enq_ready),
    .tx_enq_data  (tx_enq_data),
    .rx_deq_valid (rx_deq_valid),
    .rx_deq_ready (rx_deq_ready),
    .rx_deq_data  (rx_deq_data)
  );

  byte_fifo #(.LOGDEPTH(`FIFO_LOGDEPTH)) tx_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .enq_valid (tx_enq_valid),
    .enq_ready (tx_enq_ready),
    .enq_data  (tx_enq_data),
    .deq_valid (tx_deq_valid),
    .deq_ready (tx_deq_ready),
    .deq_data  (tx_deq_data)
  );

  byte_fifo #(.LOGDEPTH(`FIFO_LOGDEPTH)) rx_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .enq_valid (rx_enq_valid),
    .enq_ready (rx_enq_ready),  // Full FIFO loses the byte
    .enq_data  (rx_enq_data),
    .deq_valid (rx_deq_valid),
    .deq_ready (rx_deq_ready),
    .deq_data  (rx_deq_data)
  );

  uart_tx #(.CLKS_PER_BIT(`UART_CLKS_PER_BIT)) tx (
    .clk        (clk),
    .arst_n     (arst_n),
    .data       (tx_deq_data),
    .valid      (tx_deq_valid),
    .ready      (tx_deq_ready),
    .serial_out (serial_tx)
  );

  uart_rx #(.CLKS_PER_BIT(`UART_CLKS_PER_BIT)) rx (
    .clk       (clk),
    .arst_n    (arst_n),
    .serial_in (serial_rx),
    .data      (rx_enq_data),
    .valid     (rx_enq_valid),
    .ready     (rx_enq_ready)
  );

endmodule

`default_nettype wire

//--- bench/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic arst_n
);
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Released on a rising edge
  initial begin
    arst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/tb_uart_mmio.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_mmio_consts.svh"

module tb_uart_mmio import uart_mmio_pkg::*; ();
  localparam int  PERIOD_NS  = 40;
  localparam time CLK_PERIOD = time'(PERIOD_NS);
  localparam int  CPB        = `UART_CLKS_PER_BIT;
  localparam int  FIFO_DEPTH = 1 << `FIFO_LOGDEPTH;
  // 40 frame times plus 2000 cycles
  localparam time TIMEOUT    = time'(40 * 10 * CPB + 2000) * CLK_PERIOD;

  logic      clk;
  logic      arst_n;
  mmio_req_t req;
  mmio_rsp_t rsp;
  logic      serial_rx;
  logic      serial_tx;
  byte_t     tx_expected[$];  // Bytes accepted by the TX FIFO in order
  int        frames_seen = 0;

  tb_clkgen #(.PERIOD(PERIOD_NS), .RESET_CYCLES(8)) clkgen (.clk(clk), .arst_n(arst_n));

  uart_mmio_top dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .rsp       (rsp),
    .serial_rx (serial_rx),
    .serial_tx (serial_tx)
  );

  task automatic stop_on_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // rvalid exactly one cycle after each read and never otherwise
  rvalid_after_read: assert property (@(posedge clk) disable iff (!arst_n)
    rsp.rvalid == $past(req.re))
    else stop_on_error("rsp.rvalid does not follow req.re by one cycle");

  // Takes one request on t_edge and samples rdata mid-cycle after it
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic we, output logic [31:0] rdata,
                            output time t_edge);
    @(posedge clk);
    req <= '{addr: addr, wdata: wdata, we: we, re: !we};
    @(posedge clk);
    t_edge = $time;
    req <= '0;
    @(negedge clk);
    rdata = rsp.rdata;
  endtask

  task automatic send_serial(input byte_t data);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, data, 1'b0};  // Stop, data LSB first, start
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      serial_rx <= frame[i];
      repeat (CPB - 1) @(posedge clk);
    end
  endtask

  initial begin : tx_monitor
    logic [9:0] frame;
    byte_t      expected;
    int         b;
    int         c;
    forever begin
      @(negedge serial_tx);
      for (b = 0; b < 10; b++) begin
        for (c = 0; c < CPB; c++) begin
          @(negedge clk);
          if (c == 0) begin
            frame[b] = serial_tx;
          end else begin
            assert (serial_tx == frame[b])
              else stop_on_error($sformatf("serial_tx changed inside bit %0d", b));
          end
        end
      end
      assert (frame[0] == 1'b0 && frame[9] == 1'b1)
        else stop_on_error("serial_tx frame has a bad start or stop bit");
      assert (tx_expected.size() > 0)
        else stop_on_error("serial_tx sent a byte that was never accepted");
      expected = tx_expected.pop_front();
      assert (frame[8:1] == expected)
        else stop_on_error($sformatf("serial_tx sent %02h, expected %02h",
                                     frame[8:1], expected));
      frames_seen++;
    end
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("Timeout: the tests did not finish in %0t ns", TIMEOUT);
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    logic [31:0] rd;
    logic [31:0] c0;
    time         t0;
    time         t1;
    byte_t       b;
    int          n;
    int          fifo_cnt;
    int          accepted;
    logic        ser_busy;
    logic        push;
    logic        pop;

    req       <= '0;
    serial_rx <= 1'b1;
    n = $urandom(32'h9745_e627);
    @(posedge arst_n);

    // Idle state after reset
    @(negedge clk);
    assert (serial_tx === 1'b1 && rsp.rvalid === 1'b0)
      else stop_on_error("serial_tx or rvalid wrong after reset");
    bus_access(`MMIO_ADDR_STATUS, '0, 1'b0, rd, t0);
    assert (rd == 32'h1) else stop_on_error($sformatf("status %08h after reset", rd));
    bus_access(32'h8000_000c, '0, 1'b0, rd, t0);  // Unmapped
    assert (rd == '0) else stop_on_error($sformatf("unmapped read gave %08h", rd));

    // Eight bytes out on serial_tx
    repeat (8) begin
      b = byte_t'($urandom);
      tx_expected.push_back(b);
      bus_access(`MMIO_ADDR_TX_DATA, {24'b0, b}, 1'b1, rd, t0);
    end
    wait (frames_seen == 8);

    // Frames into serial_rx with status polling
    repeat (4) begin
      b = byte_t'($urandom);
      send_serial(b);
      rd = '0;
      while (rd[1] == 1'b0) bus_access(`MMIO_ADDR_STATUS, '0, 1'b0, rd, t0);
      bus_access(`MMIO_ADDR_RX_DATA, '0, 1'b0, rd, t0);
      assert (rd == {24'b0, b})
        else stop_on_error($sformatf("RX data %08h, expected %02h", rd, b));
    end
    bus_access(`MMIO_ADDR_STATUS, '0, 1'b0, rd, t0);
    assert (rd[1] == 1'b0) else stop_on_error("rx_valid still set after the last byte");

    // 40 back to back writes against a FIFO model
    fifo_cnt = 0;
    accepted = 0;
    ser_busy = 1'b0;
    for (n = 0; n < 40; n++) begin
      b = byte_t'($urandom);
      @(posedge clk);
      req <= '{addr: `MMIO_ADDR_TX_DATA, wdata: {24'b0, b}, we: 1'b1, re: 1'b0};
      push = (fifo_cnt < FIFO_DEPTH);
      pop  = (fifo_cnt > 0) && !ser_busy;  // Serializer takes the head while idle
      if (push) begin
        tx_expected.push_back(b);
        accepted++;
      end
      if (pop) ser_busy = 1'b1;
      fifo_cnt = fifo_cnt + int'(push) - int'(pop);
    end
    @(posedge clk);
    req <= '0;
    bus_access(`MMIO_ADDR_STATUS, '0, 1'b0, rd, t0);
    assert (rd[0] == 1'b0) else stop_on_error("tx_ready still set with the TX FIFO full");
    wait (frames_seen == 8 + accepted);
    repeat (2) @(negedge clk);
    assert (serial_tx == 1'b1)
      else stop_on_error("serial_tx did not go idle after the accepted bytes");

    // Cycle counter
    n = $urandom_range(60, 5);
    bus_access(`MMIO_ADDR_CYCLES, '0, 1'b0, c0, t0);
    repeat (n) @(posedge clk);
    bus_access(`MMIO_ADDR_CYCLES, '0, 1'b0, rd, t1);
    assert (rd - c0 == 32'((t1 - t0) / CLK_PERIOD))
      else stop_on_error($sformatf("counter moved by %0d", rd - c0));
    n = $urandom_range(30, 2);
    bus_access(`MMIO_ADDR_CNT_RST, '0, 1'b1, rd, t0);
    repeat (n) @(posedge clk);
    bus_access(`MMIO_ADDR_CYCLES, '0, 1'b0, rd, t1);
    assert (rd == 32'((t1 - t0) / CLK_PERIOD) - 32'd1)
      else stop_on_error($sformatf("counter read %0d after clear", rd));

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- uart_mmio.f
+incdir+common
common/uart_mmio_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
design/byte_fifo.sv
design/mmio_regs.sv
design/uart_mmio_top.sv
bench/tb_clkgen.sv
bench/tb_uart_mmio.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_uart_mmio -f uart_mmio.f \
  -o sim_uart_mmio > sim.log 2>&1 &&
  ./obj_dir/sim_uart_mmio >> sim.log 2>&1
cat sim.log
# Any failure line, or a run that never reached the end, fails the script
! grep -q "TB FAILED" sim.log && grep -q "TB PASSED" sim.log
